/* source/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    // Lane and tap counts
    localparam int LANES     = 4;
    localparam int FFE_TAPS  = 3;
    localparam int CHAN_TAPS = 3;

    // Sample and coefficient widths
    typedef logic signed [7:0]  code_t;
    typedef logic signed [5:0]  weight_t;
    typedef logic signed [15:0] ffe_acc_t;
    typedef logic        [3:0]  shift_t;
    typedef logic signed [15:0] thresh_t;
    typedef logic signed [7:0]  chan_tap_t;
    typedef logic signed [11:0] est_t;
    typedef logic signed [12:0] err_t;

    // Lane 0 holds the oldest sample of a word
    typedef struct packed {
        code_t [LANES-1:0] lane;
    } code_word_t;

    typedef struct packed {
        logic [LANES-1:0] lane;
    } bit_word_t;

    typedef struct packed {
        err_t [LANES-1:0] lane;
    } err_word_t;

    // Static datapath configuration, tap 0 is the current sample
    typedef struct packed {
        weight_t   [FFE_TAPS-1:0]  ffe_weight;
        shift_t                    ffe_shift;
        thresh_t                   thresh;
        chan_tap_t [CHAN_TAPS-1:0] chan_tap;
        shift_t                    chan_shift;
    } dsp_cfg_t;

    // Whether the history word holds real data since reset
    typedef enum logic {
        HIST_EMPTY,
        HIST_FULL
    } hist_state_t;

endpackage : dsp_pkg

`default_nettype wire

/* source/ffe_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_slicer (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                codes_valid_i,
    input  dsp_pkg::code_word_t codes_i,
    input  dsp_pkg::dsp_cfg_t   cfg_i,

    output logic                bits_valid_o,
    output dsp_pkg::bit_word_t  bits_o
);
    import dsp_pkg::*;

    code_word_t  prev_codes;
    hist_state_t hist_state;
    bit_word_t   bits_nxt;

    // FFE and slicer per lane
    // Samples before lane 0 come from the previous word
    always_comb begin
        ffe_acc_t acc;
        ffe_acc_t shifted;
        code_t    tap_code;
        weight_t  tap_weight;
        int       idx;

        bits_nxt = '0;
        for (int i = 0; i < LANES; i++) begin
            acc = '0;
            for (int k = 0; k < FFE_TAPS; k++) begin
                idx = i - k;
                if (idx >= 0) begin
                    tap_code = codes_i.lane[idx];
                end else begin
                    tap_code = prev_codes.lane[LANES + idx];
                end
                tap_weight = cfg_i.ffe_weight[k];
                acc = acc + ffe_acc_t'(tap_weight) * ffe_acc_t'(tap_code);
            end
            shifted = acc >>> cfg_i.ffe_shift;
            bits_nxt.lane[i] = (shifted >= cfg_i.thresh);
        end
    end

    // Control state and history
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bits_valid_o <= 1'b0;
            prev_codes   <= '0;
            hist_state   <= HIST_EMPTY;
        end else begin
            bits_valid_o <= codes_valid_i;
            if (codes_valid_i) begin
                prev_codes <= codes_i;
                hist_state <= HIST_FULL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (codes_valid_i) begin
            bits_o <= bits_nxt;
        end
    end

    // One cycle from code strobe to bit strobe
    a_bits_follow_codes: assert property (
        @(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> (bits_valid_o == $past(codes_valid_i))
    ) else $error("bits_valid_o does not follow codes_valid_i by one cycle");

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (rst_i)
        $past(rst_i) |-> !bits_valid_o
    ) else $error("bits_valid_o high in the first cycle after reset");

    // Empty history must still read as zero
    a_empty_hist_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        (hist_state == HIST_EMPTY) |-> (prev_codes == '0)
    ) else $error("code history not zero before the first word");

endmodule : ffe_slicer

`default_nettype wire

/* source/code_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module code_delay_line #(
    parameter int DEPTH = 1
) (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                valid_i,
    input  dsp_pkg::code_word_t codes_i,

    output logic                valid_o,
    output dsp_pkg::code_word_t codes_o
);
    import dsp_pkg::*;

    if (DEPTH < 1) begin : g_depth_check
        $error("code_delay_line needs DEPTH of at least 1, got %0d", DEPTH);
    end

    logic [DEPTH-1:0] valid_pipe;
    code_word_t       code_pipe [DEPTH];

    // Stage 0 takes the input, each later stage the one before
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_pipe <= '0;
            for (int s = 0; s < DEPTH; s++) begin
                code_pipe[s] <= '0;
            end
        end else begin
            valid_pipe[0] <= valid_i;
            code_pipe[0]  <= codes_i;
            for (int s = 1; s < DEPTH; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
                code_pipe[s]  <= code_pipe[s-1];
            end
        end
    end

    assign valid_o = valid_pipe[DEPTH-1];
    assign codes_o = code_pipe[DEPTH-1];

endmodule : code_delay_line

`default_nettype wire

/* source/channel_error.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_error (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                bits_valid_i,
    input  dsp_pkg::bit_word_t  bits_i,
    input  logic                codes_valid_i,
    input  dsp_pkg::code_word_t codes_i,
    input  dsp_pkg::dsp_cfg_t   cfg_i,

    output logic                err_valid_o,
    output dsp_pkg::err_word_t  err_o
);
    import dsp_pkg::*;

    bit_word_t   prev_bits;
    hist_state_t hist_state;
    err_word_t   err_nxt;

    // Channel filter, a 1 adds the tap and a 0 subtracts it
    always_comb begin
        est_t      est;
        code_t     raw;
        chan_tap_t tap;
        logic      past_bit;
        int        idx;

        err_nxt = '0;
        for (int i = 0; i < LANES; i++) begin
            est = '0;
            for (int k = 0; k < CHAN_TAPS; k++) begin
                idx = i - k;
                if (idx >= 0) begin
                    past_bit = bits_i.lane[idx];
                end else begin
                    past_bit = prev_bits.lane[LANES + idx];
                end
                tap = cfg_i.chan_tap[k];
                if (past_bit) begin
                    est = est + est_t'(tap);
                end else begin
                    est = est - est_t'(tap);
                end
            end
            est = est >>> cfg_i.chan_shift;
            raw = codes_i.lane[i];
            err_nxt.lane[i] = err_t'(est) - err_t'(raw);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_valid_o <= 1'b0;
            prev_bits   <= '0;
            hist_state  <= HIST_EMPTY;
        end else begin
            err_valid_o <= bits_valid_i;
            if (bits_valid_i) begin
                prev_bits  <= bits_i;
                hist_state <= HIST_FULL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bits_valid_i) begin
            err_o <= err_nxt;
        end
    end

    // Raw codes from the delay line must meet their own bits
    a_codes_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        codes_valid_i == bits_valid_i
    ) else $error("delayed code strobe not aligned with bit strobe");

    a_err_follows_bits: assert property (
        @(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> (err_valid_o == $past(bits_valid_i))
    ) else $error("err_valid_o does not follow bits_valid_i by one cycle");

    a_empty_hist_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        (hist_state == HIST_EMPTY) |-> (prev_bits == '0)
    ) else $error("bit history not zero before the first word");

endmodule : channel_error

`default_nettype wire

/* source/rx_dsp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_dsp_top (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                codes_valid_i,
    input  dsp_pkg::code_word_t codes_i,
    // Held stable while data flows
    input  dsp_pkg::dsp_cfg_t   cfg_i,

    output logic                bits_valid_o,
    output dsp_pkg::bit_word_t  bits_o,
    output logic                err_valid_o,
    output dsp_pkg::err_word_t  err_o
);
    import dsp_pkg::*;

    // Matches the one-cycle latency of the FFE and slicer
    localparam int CODE_DELAY = 1;

    logic       bits_valid;
    bit_word_t  bits;
    logic       dly_valid;
    code_word_t dly_codes;

    ffe_slicer u_ffe_slicer (
        .clk           (clk),
        .rst_i         (rst_i),
        .codes_valid_i (codes_valid_i),
        .codes_i       (codes_i),
        .cfg_i         (cfg_i),
        .bits_valid_o  (bits_valid),
        .bits_o        (bits)
    );

    code_delay_line #(
        .DEPTH (CODE_DELAY)
    ) u_code_delay (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (codes_valid_i),
        .codes_i (codes_i),
        .valid_o (dly_valid),
        .codes_o (dly_codes)
    );

    channel_error u_channel_error (
        .clk           (clk),
        .rst_i         (rst_i),
        .bits_valid_i  (bits_valid),
        .bits_i        (bits),
        .codes_valid_i (dly_valid),
        .codes_i       (dly_codes),
        .cfg_i         (cfg_i),
        .err_valid_o   (err_valid_o),
        .err_o         (err_o)
    );

    assign bits_valid_o = bits_valid;
    assign bits_o       = bits;

endmodule : rx_dsp_top

`default_nettype wire

/* include/rx_dsp_model.svh */
`ifndef RX_DSP_MODEL_SVH
`define RX_DSP_MODEL_SVH

// Last accepted word of each stage, zero after reset
code_word_t model_prev_codes;
bit_word_t  model_prev_bits;

function automatic void reset_model_history();
    model_prev_codes = '0;
    model_prev_bits  = '0;
endfunction

// Expected bits and errors of one accepted word, then advance the history
function automatic void predict_word(
    input  code_word_t codes,
    input  dsp_cfg_t   cfg,
    output bit_word_t  bits,
    output err_word_t  errs
);
    int code_hist [2*LANES];
    int bit_hist  [2*LANES];
    int sum;
    int est;

    // Index LANES + n is sample n of this word, lower indices reach back
    for (int j = 0; j < LANES; j++) begin
        code_hist[j]         = $signed(model_prev_codes.lane[j]);
        code_hist[LANES + j] = $signed(codes.lane[j]);
        bit_hist[j]          = model_prev_bits.lane[j];
    end
    for (int i = 0; i < LANES; i++) begin
        sum = 0;
        for (int k = 0; k < FFE_TAPS; k++) begin
            sum = sum + $signed(cfg.ffe_weight[k]) * code_hist[LANES + i - k];
        end
        bits.lane[i]        = ((sum >>> cfg.ffe_shift) >= $signed(cfg.thresh));
        bit_hist[LANES + i] = bits.lane[i];
    end
    for (int i = 0; i < LANES; i++) begin
        est = 0;
        for (int k = 0; k < CHAN_TAPS; k++) begin
            if (bit_hist[LANES + i - k] == 1) begin
                est = est + $signed(cfg.chan_tap[k]);
            end else begin
                est = est - $signed(cfg.chan_tap[k]);
            end
        end
        est          = est >>> cfg.chan_shift;
        errs.lane[i] = err_t'(est - code_hist[LANES + i]);
    end
    model_prev_codes = codes;
    model_prev_bits  = bits;
endfunction

`endif

/* tb/tb_rx_dsp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_dsp_top;
    import dsp_pkg::*;

    `include "rx_dsp_model.svh"

    logic       clk;
    logic       rst_i;
    logic       codes_valid_i;
    code_word_t codes_i;
    dsp_cfg_t   cfg_i;
    logic       bits_valid_o;
    bit_word_t  bits_o;
    logic       err_valid_o;
    err_word_t  err_o;

    // Expected words and the compare cycle at which each must appear
    bit_word_t exp_bits_q [$];
    err_word_t exp_err_q [$];
    int        bits_due_q [$];
    int        err_due_q [$];
    bit_word_t exp_bits;
    err_word_t exp_errs;
    int        due;
    int        cyc = 0;
    logic      checks_on = 1'b0;
    int        value_errs = 0;
    int        timing_errs = 0;
    int        protocol_errs = 0;
    int        timeout_errs = 0;

    rx_dsp_top i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .codes_valid_i (codes_valid_i),
        .codes_i       (codes_i),
        .cfg_i         (cfg_i),
        .bits_valid_o  (bits_valid_o),
        .bits_o        (bits_o),
        .err_valid_o   (err_valid_o),
        .err_o         (err_o)
    );

    always #4 clk = ~clk;

    function automatic code_word_t random_codes();
        code_word_t w;
        for (int i = 0; i < LANES; i++) begin
            w.lane[i] = code_t'($urandom);
        end
        return w;
    endfunction

    function automatic dsp_cfg_t random_cfg();
        dsp_cfg_t c;
        for (int k = 0; k < FFE_TAPS; k++) begin
            c.ffe_weight[k] = weight_t'($urandom);
        end
        for (int k = 0; k < CHAN_TAPS; k++) begin
            c.chan_tap[k] = chan_tap_t'($urandom);
        end
        c.ffe_shift  = shift_t'($urandom_range(0, 6));
        // Threshold near zero so both bit values show up
        c.thresh     = thresh_t'(int'($urandom_range(0, 128)) - 64);
        c.chan_shift = shift_t'($urandom_range(0, 3));
        return c;
    endfunction

    function automatic dsp_cfg_t identity_cfg();
        dsp_cfg_t c;
        c               = '0;
        c.ffe_weight[0] = 6'sd1;
        c.chan_tap[0]   = 8'sd64;
        return c;
    endfunction

    task automatic apply_reset(input int cycles);
        rst_i         = 1'b1;
        codes_valid_i = 1'b0;
        reset_model_history();
        @(negedge clk);
        checks_on = 1'b1;
        repeat (cycles - 1) @(negedge clk);
        rst_i = 1'b0;
    endtask

    task automatic send_word(input code_word_t word);
        bit_word_t bits;
        err_word_t errs;
        codes_valid_i = 1'b1;
        codes_i       = word;
        predict_word(word, cfg_i, bits, errs);
        exp_bits_q.push_back(bits);
        bits_due_q.push_back(cyc + 2);
        exp_err_q.push_back(errs);
        err_due_q.push_back(cyc + 3);
        @(negedge clk);
        codes_valid_i = 1'b0;
    endtask

    // Idle data is random to show that it never reaches the history
    task automatic idle_cycles(input int n);
        repeat (n) begin
            codes_valid_i = 1'b0;
            codes_i       = random_codes();
            @(negedge clk);
        end
    endtask

    task automatic wait_for_drain();
        int n;
        n = 0;
        while ((exp_bits_q.size() != 0 || exp_err_q.size() != 0) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_bits_q.size() != 0 || exp_err_q.size() != 0) begin
            timeout_errs++;
            $display("ERROR: timeout, %0d bit words and %0d error words never arrived",
                     exp_bits_q.size(), exp_err_q.size());
            exp_bits_q.delete();
            bits_due_q.delete();
            exp_err_q.delete();
            err_due_q.delete();
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (checks_on && $isunknown({bits_valid_o, err_valid_o})) begin
            protocol_errs++;
            $display("ERROR: output strobe unknown at cycle %0d", cyc);
        end
        if (bits_valid_o === 1'b1) begin
            if (exp_bits_q.size() == 0) begin
                protocol_errs++;
                $display("ERROR: bits strobe at cycle %0d without an accepted word", cyc);
            end else begin
                exp_bits = exp_bits_q.pop_front();
                due      = bits_due_q.pop_front();
                if (due != cyc) begin
                    timing_errs++;
                    $display("ERROR: bits due at cycle %0d arrived at cycle %0d", due, cyc);
                end
                if (bits_o !== exp_bits) begin
                    value_errs++;
                    $display("FAIL bits_o expected %h got %h", exp_bits, bits_o);
                end
            end
        end
        if (err_valid_o === 1'b1) begin
            if (exp_err_q.size() == 0) begin
                protocol_errs++;
                $display("ERROR: error strobe at cycle %0d without an accepted word", cyc);
            end else begin
                exp_errs = exp_err_q.pop_front();
                due      = err_due_q.pop_front();
                if (due != cyc) begin
                    timing_errs++;
                    $display("ERROR: errors due at cycle %0d arrived at cycle %0d", due, cyc);
                end
                if (err_o !== exp_errs) begin
                    value_errs++;
                    $display("FAIL err_o expected %h got %h", exp_errs, err_o);
                end
            end
        end
    end

    initial begin
        void'($urandom(30));
        clk           = 1'b0;
        rst_i         = 1'b1;
        codes_valid_i = 1'b0;
        codes_i       = '0;
        cfg_i         = identity_cfg();
        apply_reset(4);
        idle_cycles(6);

        repeat (32) send_word(random_codes());
        wait_for_drain();

        // Back to back words
        repeat (8) begin
            cfg_i = random_cfg();
            repeat (16) send_word(random_codes());
            wait_for_drain();
        end

        // Gaps between strobes
        repeat (4) begin
            cfg_i = random_cfg();
            repeat (24) begin
                send_word(random_codes());
                idle_cycles($urandom_range(0, 3));
            end
            wait_for_drain();
        end

        // Reset in mid-stream, both history words start from zero again
        repeat (2) begin
            cfg_i = random_cfg();
            repeat (10) send_word(random_codes());
            wait_for_drain();
            apply_reset(4);
            idle_cycles($urandom_range(0, 2));
            repeat (10) send_word(random_codes());
            wait_for_drain();
        end

        idle_cycles(4);
        $display("Errors: %0d value, %0d timing, %0d protocol, %0d timeout",
                 value_errs, timing_errs, protocol_errs, timeout_errs);
        if (value_errs + timing_errs + protocol_errs + timeout_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_rx_dsp_top

`default_nettype wire

/* sim.f */
+incdir+include
source/dsp_pkg.sv
source/ffe_slicer.sv
source/code_delay_line.sv
source/channel_error.sv
source/rx_dsp_top.sv
tb/tb_rx_dsp_top.sv

/* Bender.yml */
package:
  name: rx_dsp

sources:
  - files:
      - source/dsp_pkg.sv
      - source/ffe_slicer.sv
      - source/code_delay_line.sv
      - source/channel_error.sv
      - source/rx_dsp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rx_dsp_top.sv
